// File: lsu_defs.svh
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// data and address width
`define LSU_XLEN 32

// memory-op codes from the decode stage
`define LSU_MEMOP_LEN 4
`define MEMOP_NONE 4'd0
`define MEMOP_LB   4'd1
`define MEMOP_LBU  4'd2
`define MEMOP_LH   4'd3
`define MEMOP_LHU  4'd4
`define MEMOP_LW   4'd5
`define MEMOP_SB   4'd6
`define MEMOP_SH   4'd7
`define MEMOP_SW   4'd8
`define MEMOP_LR_W 4'd9
`define MEMOP_SC_W 4'd10
`define MEMOP_AMO  4'd11

// amo sub-ops, only meaningful with MEMOP_AMO
`define LSU_AMOOP_LEN 4
`define AMOOP_SWAP 4'd0
`define AMOOP_ADD  4'd1
`define AMOOP_XOR  4'd2
`define AMOOP_AND  4'd3
`define AMOOP_OR   4'd4
`define AMOOP_MIN  4'd5
`define AMOOP_MAX  4'd6
`define AMOOP_MINU 4'd7
`define AMOOP_MAXU 4'd8

// clint timer registers, word addresses
`define MTIME_ADDR_LOW     32'h0200_bff8
`define MTIME_ADDR_HIGH    32'h0200_bffc
`define MTIMECMP_ADDR_LOW  32'h0200_4000
`define MTIMECMP_ADDR_HIGH 32'h0200_4004

`endif

// File: lsu_pkg.sv
`include "lsu_defs.svh"

package lsu_pkg;

    // one bus word, seen whole or by lane
    // byte lane 0 is the lowest address
    typedef union packed {
        logic [`LSU_XLEN-1:0]           word;
        logic [`LSU_XLEN/8-1:0][7:0]    bytes;
        logic [`LSU_XLEN/16-1:0][15:0]  halves;
    } bus_word_u;

endpackage

// File: lsu_access_decode.sv
`include "lsu_defs.svh"

module lsu_access_decode (
    input  logic [`LSU_MEMOP_LEN-1:0] mem_op_i,
    output logic                      is_load_o,
    output logic                      is_store_o,
    output logic                      is_lr_o,
    output logic                      is_sc_o,
    output logic                      is_amo_o,
    output logic                      ls_signed_o,
    output logic [3:0]                ls_size_o,
    output logic [3:0]                base_mask_o
);

    logic op_byte;
    logic op_half;
    logic op_word;

    // plain loads and stores
    assign is_load_o  = (mem_op_i == `MEMOP_LB) | (mem_op_i == `MEMOP_LBU) |
                        (mem_op_i == `MEMOP_LH) | (mem_op_i == `MEMOP_LHU) |
                        (mem_op_i == `MEMOP_LW);
    assign is_store_o = (mem_op_i == `MEMOP_SB) | (mem_op_i == `MEMOP_SH) |
                        (mem_op_i == `MEMOP_SW);

    // atomic class
    assign is_lr_o  = (mem_op_i == `MEMOP_LR_W);
    assign is_sc_o  = (mem_op_i == `MEMOP_SC_W);
    assign is_amo_o = (mem_op_i == `MEMOP_AMO);

    // only sub-word loads care about sign
    assign ls_signed_o = (mem_op_i == `MEMOP_LB) | (mem_op_i == `MEMOP_LH);

    // access width
    assign op_byte = (mem_op_i == `MEMOP_LB) | (mem_op_i == `MEMOP_LBU) |
                     (mem_op_i == `MEMOP_SB);
    assign op_half = (mem_op_i == `MEMOP_LH) | (mem_op_i == `MEMOP_LHU) |
                     (mem_op_i == `MEMOP_SH);
    // atomics are always word wide
    assign op_word = (mem_op_i == `MEMOP_LW) | (mem_op_i == `MEMOP_SW) |
                     is_lr_o | is_sc_o | is_amo_o;

    // one-hot, bit 3 reserved for a future doubleword
    assign ls_size_o = {1'b0, op_word, op_half, op_byte};

    // lane mask before the address shift
    assign base_mask_o = ({4{op_byte}} & 4'b0001) |
                         ({4{op_half}} & 4'b0011) |
                         ({4{op_word}} & 4'b1111);

endmodule

// File: lsu_store_align.sv
`include "lsu_defs.svh"

module lsu_store_align (
    input  logic [3:0]              base_mask_i,
    input  logic [1:0]              addr_lo_i,
    input  logic [`LSU_XLEN-1:0]    store_data_i,
    input  logic                    word_access_i,
    output logic [3:0]              wmask_o,
    output lsu_pkg::bus_word_u      wdata_o
);

    import lsu_pkg::*;

    bus_word_u src;

    assign src = store_data_i;

    // mask follows the data lanes
    assign wmask_o = word_access_i ? base_mask_i : (base_mask_i << addr_lo_i);

    always_comb begin
        if (word_access_i) begin
            // word and atomic data go out as is
            wdata_o = src;
        end else begin
            // move the low lane up to the addressed offset
            case (addr_lo_i)
                2'd0: wdata_o.word = src.word;
                2'd1: wdata_o.bytes = {src.bytes[2:0], 8'h00};
                2'd2: wdata_o.halves = {src.halves[0], 16'h0000};
                default: wdata_o.bytes = {src.bytes[0], 24'h00_0000};
            endcase
        end
    end

endmodule

// File: lsu_load_extend.sv
`include "lsu_defs.svh"

module lsu_load_extend (
    input  lsu_pkg::bus_word_u      rdata_i,
    input  logic [1:0]              addr_lo_i,
    input  logic [3:0]              ls_size_i,
    input  logic                    ls_signed_i,
    output logic [`LSU_XLEN-1:0]    data_o
);

    logic [7:0]  byte_lane;
    logic [15:0] half_lane;
    logic        byte_fill;
    logic        half_fill;

    // pick the lane the address points at
    assign byte_lane = rdata_i.bytes[addr_lo_i];
    // halfword lane from bit 1 only
    assign half_lane = rdata_i.halves[addr_lo_i[1]];

    // fill bit is the lane msb for signed loads
    assign byte_fill = ls_signed_i & byte_lane[7];
    assign half_fill = ls_signed_i & half_lane[15];

    always_comb begin
        case (ls_size_i)
            4'b0001: data_o = {{(`LSU_XLEN-8){byte_fill}}, byte_lane};
            4'b0010: data_o = {{(`LSU_XLEN-16){half_fill}}, half_lane};
            // word or no access, whole word
            default: data_o = rdata_i.word;
        endcase
    end

endmodule

// File: lsu_amo_unit.sv
`include "lsu_defs.svh"

module lsu_amo_unit (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        amo_valid_i,
    input  logic                        is_lr_i,
    input  logic                        is_sc_i,
    input  logic                        is_amo_i,
    input  logic                        plain_store_i,
    input  logic [`LSU_AMOOP_LEN-1:0]   amo_op_i,
    input  logic [`LSU_XLEN-1:0]        addr_i,
    input  logic [`LSU_XLEN-1:0]        rs2_i,
    input  logic [`LSU_XLEN-1:0]        rdata_i,
    input  logic                        ready_i,
    output logic                        amo_mem_req_o,
    output logic                        amo_mem_write_o,
    output logic [`LSU_XLEN-1:0]        store_data_o,
    output logic [`LSU_XLEN-1:0]        amo_result_o,
    output logic                        amo_done_o,
    output logic                        busy_o
);

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_LOAD  = 2'd1;
    localparam logic [1:0] ST_CALC  = 2'd2;
    localparam logic [1:0] ST_STORE = 2'd3;

    logic [1:0]             state_q;
    logic                   valid_q;
    logic                   done_q;
    logic                   res_valid_q;
    logic [`LSU_XLEN-1:0]   res_addr_q;
    logic [`LSU_XLEN-1:0]   loaded_q;
    logic [`LSU_XLEN-1:0]   calc_q;
    logic [`LSU_XLEN-1:0]   result_q;
    logic [`LSU_XLEN-1:0]   calc_next;
    logic                   start;
    logic                   sc_hit;
    logic                   load_fire;
    logic                   store_fire;
    logic                   signed_lt;
    logic                   unsigned_lt;

    // new atomic only on the rising edge of the request while idle
    assign start = amo_valid_i & ~valid_q & (state_q == ST_IDLE) &
                   (is_lr_i | is_sc_i | is_amo_i);

    // sc succeeds only on a live reservation for this word
    assign sc_hit = res_valid_q & (res_addr_q == addr_i);

    assign load_fire  = (state_q == ST_LOAD) & ready_i;
    assign store_fire = (state_q == ST_STORE) & ready_i;

    // signs differ means the negative one is smaller
    // same sign compares on the low bits directly
    assign signed_lt = (loaded_q[`LSU_XLEN-1] != rs2_i[`LSU_XLEN-1]) ?
                       loaded_q[`LSU_XLEN-1] :
                       (loaded_q[`LSU_XLEN-2:0] < rs2_i[`LSU_XLEN-2:0]);
    assign unsigned_lt = (loaded_q < rs2_i);

    // new memory value from old value and rs2
    always_comb begin
        case (amo_op_i)
            `AMOOP_ADD:  calc_next = loaded_q + rs2_i;
            `AMOOP_XOR:  calc_next = loaded_q ^ rs2_i;
            `AMOOP_AND:  calc_next = loaded_q & rs2_i;
            `AMOOP_OR:   calc_next = loaded_q | rs2_i;
            `AMOOP_MIN:  calc_next = signed_lt ? loaded_q : rs2_i;
            `AMOOP_MAX:  calc_next = signed_lt ? rs2_i : loaded_q;
            `AMOOP_MINU: calc_next = unsigned_lt ? loaded_q : rs2_i;
            `AMOOP_MAXU: calc_next = unsigned_lt ? rs2_i : loaded_q;
            // swap and unknown codes write rs2
            default:     calc_next = rs2_i;
        endcase
    end

    // fsm, edge detect and reservation flag
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q     <= ST_IDLE;
            valid_q     <= 1'b0;
            done_q      <= 1'b0;
            res_valid_q <= 1'b0;
        end else begin
            valid_q <= amo_valid_i;
            done_q  <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (start) begin
                        if (is_sc_i & ~sc_hit) begin
                            // failed sc, no memory traffic
                            done_q      <= 1'b1;
                            res_valid_q <= 1'b0;
                        end else if (is_sc_i) begin
                            state_q <= ST_STORE;
                        end else begin
                            state_q <= ST_LOAD;
                        end
                    end
                end
                ST_LOAD: begin
                    if (ready_i) begin
                        if (is_lr_i) begin
                            // lr ends here and takes the reservation
                            res_valid_q <= 1'b1;
                            done_q      <= 1'b1;
                            state_q     <= ST_IDLE;
                        end else begin
                            state_q <= ST_CALC;
                        end
                    end
                end
                ST_CALC: begin
                    // one cycle for the alu result
                    state_q <= ST_STORE;
                end
                default: begin
                    if (ready_i) begin
                        // sc and amo writes both drop the reservation
                        res_valid_q <= 1'b0;
                        done_q      <= 1'b1;
                        state_q     <= ST_IDLE;
                    end
                end
            endcase
            // any plain store breaks the lr/sc pair
            if (plain_store_i) begin
                res_valid_q <= 1'b0;
            end
        end
    end

    // data path registers
    always_ff @(posedge clk) begin
        if (start & is_sc_i & ~sc_hit) begin
            result_q <= `LSU_XLEN'(1);
        end
        if (load_fire) begin
            loaded_q <= rdata_i;
            if (is_lr_i) begin
                result_q   <= rdata_i;
                res_addr_q <= addr_i;
            end
        end
        if (state_q == ST_CALC) begin
            calc_q <= calc_next;
        end
        if (store_fire) begin
            // sc returns 0 on success, amo the old word
            result_q <= is_sc_i ? '0 : loaded_q;
        end
    end

    assign amo_mem_req_o   = (state_q == ST_LOAD) | (state_q == ST_STORE);
    assign amo_mem_write_o = (state_q == ST_STORE);

    // amo writes the computed word, sc and plain stores write rs2
    assign store_data_o = is_amo_i ? calc_q : rs2_i;

    assign amo_result_o = result_q;
    assign amo_done_o   = done_q;
    assign busy_o       = (state_q != ST_IDLE);

endmodule

// File: lsu.sv
`include "lsu_defs.svh"

module lsu (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [`LSU_MEMOP_LEN-1:0]   mem_op_i,
    input  logic [`LSU_AMOOP_LEN-1:0]   amo_op_i,
    input  logic                        amo_valid_i,
    input  logic [`LSU_XLEN-1:0]        alu_data_i,
    input  logic [`LSU_XLEN-1:0]        rs2_data_i,
    // data memory port
    output logic [`LSU_XLEN-1:0]        mem_addr_o,
    output logic                        mem_addr_valid_o,
    output logic                        mem_write_valid_o,
    output logic [3:0]                  mem_mask_o,
    output logic [3:0]                  mem_size_o,
    output logic [`LSU_XLEN-1:0]        mem_wdata_o,
    input  logic                        mem_data_ready_i,
    input  logic [`LSU_XLEN-1:0]        mem_rdata_i,
    // clint port
    output logic [`LSU_XLEN-1:0]        clint_addr_o,
    output logic                        clint_valid_o,
    output logic                        clint_write_valid_o,
    output logic [`LSU_XLEN-1:0]        clint_wdata_o,
    input  logic [`LSU_XLEN-1:0]        clint_rdata_i,
    // to writeback and pipeline control
    output logic [`LSU_XLEN-1:0]        mem_data_o,
    output logic [`LSU_XLEN-1:0]        amo_result_o,
    output logic                        amo_done_o,
    output logic                        stall_o,
    output logic                        amo_misalign_o
);

    import lsu_pkg::*;

    logic                   is_load;
    logic                   is_store;
    logic                   is_lr;
    logic                   is_sc;
    logic                   is_amo;
    logic                   is_atomic;
    logic                   ls_signed;
    logic [3:0]             ls_size;
    logic [3:0]             base_mask;
    logic [3:0]             wmask;
    logic                   clint_hit;
    logic                   plain_req;
    logic                   amo_mem_req;
    logic                   amo_mem_write;
    logic                   amo_busy;
    logic [`LSU_XLEN-1:0]   store_data;
    logic [`LSU_XLEN-1:0]   load_data;
    bus_word_u              wdata_lanes;
    bus_word_u              rdata_sel;

    lsu_access_decode u_decode (
        .mem_op_i    (mem_op_i),
        .is_load_o   (is_load),
        .is_store_o  (is_store),
        .is_lr_o     (is_lr),
        .is_sc_o     (is_sc),
        .is_amo_o    (is_amo),
        .ls_signed_o (ls_signed),
        .ls_size_o   (ls_size),
        .base_mask_o (base_mask)
    );

    assign is_atomic = is_lr | is_sc | is_amo;

    // timer registers live in the clint, not in memory
    assign clint_hit = (alu_data_i == `MTIME_ADDR_LOW) |
                       (alu_data_i == `MTIME_ADDR_HIGH) |
                       (alu_data_i == `MTIMECMP_ADDR_LOW) |
                       (alu_data_i == `MTIMECMP_ADDR_HIGH);

    lsu_amo_unit u_amo (
        .clk             (clk),
        .rst             (rst),
        .amo_valid_i     (amo_valid_i),
        .is_lr_i         (is_lr),
        .is_sc_i         (is_sc),
        .is_amo_i        (is_amo),
        .plain_store_i   (is_store),
        .amo_op_i        (amo_op_i),
        .addr_i          (alu_data_i),
        .rs2_i           (rs2_data_i),
        .rdata_i         (mem_rdata_i),
        .ready_i         (mem_data_ready_i),
        .amo_mem_req_o   (amo_mem_req),
        .amo_mem_write_o (amo_mem_write),
        .store_data_o    (store_data),
        .amo_result_o    (amo_result_o),
        .amo_done_o      (amo_done_o),
        .busy_o          (amo_busy)
    );

    lsu_store_align u_store_align (
        .base_mask_i   (base_mask),
        .addr_lo_i     (alu_data_i[1:0]),
        .store_data_i  (store_data),
        .word_access_i (ls_size[2]),
        .wmask_o       (wmask),
        .wdata_o       (wdata_lanes)
    );

    // plain accesses go straight out, atomics through the fsm
    assign plain_req   = (is_load | is_store) & ~clint_hit;
    // request level drops in the ready cycle
    assign mem_addr_valid_o  = (plain_req | amo_mem_req) & ~mem_data_ready_i;
    assign mem_write_valid_o = mem_addr_valid_o & (is_store | amo_mem_write);
    assign mem_addr_o  = alu_data_i;
    assign mem_size_o  = ls_size;
    assign mem_mask_o  = mem_write_valid_o ? wmask : base_mask;
    assign mem_wdata_o = wdata_lanes.word;

    // clint answers in the same cycle, plain accesses only
    assign clint_addr_o        = alu_data_i;
    assign clint_valid_o       = clint_hit & (is_load | is_store);
    assign clint_write_valid_o = clint_hit & is_store;
    assign clint_wdata_o       = rs2_data_i;

    assign rdata_sel = clint_valid_o ? clint_rdata_i : mem_rdata_i;

    lsu_load_extend u_load_extend (
        .rdata_i     (rdata_sel),
        .addr_lo_i   (alu_data_i[1:0]),
        .ls_size_i   (ls_size),
        .ls_signed_i (ls_signed),
        .data_o      (load_data)
    );

    // writeback value
    always_comb begin
        if (is_atomic) begin
            mem_data_o = amo_result_o;
        end else if (is_load) begin
            mem_data_o = load_data;
        end else begin
            // non-memory op, alu result passes on
            mem_data_o = alu_data_i;
        end
    end

    assign stall_o = mem_addr_valid_o | (amo_busy & ~amo_done_o);

    // atomics must be word aligned
    assign amo_misalign_o = is_atomic & (alu_data_i[1:0] != 2'b00);

endmodule

// File: lsu_asserts.sv
`include "lsu_defs.svh"

module lsu_asserts (
    input logic clk,
    input logic rst,
    input logic addr_valid_i,
    input logic write_valid_i,
    input logic ready_i,
    input logic done_i,
    input logic stall_i
);

    // an unanswered request stays up
    request_held: assert property (@(posedge clk) disable iff (rst)
        addr_valid_i |=> addr_valid_i || ready_i)
        else $error("memory request dropped before ready");

    // a write keeps its write level until memory answers
    write_held: assert property (@(posedge clk) disable iff (rst)
        write_valid_i |=> write_valid_i || ready_i)
        else $error("memory write dropped before ready");

    // done is a single-cycle pulse
    done_is_pulse: assert property (@(posedge clk) disable iff (rst)
        done_i |=> !done_i)
        else $error("atomic done held high for more than one cycle");

    // back-pressure keeps the pipeline held
    stall_held: assert property (@(posedge clk) disable iff (rst)
        !ready_i && $past(stall_i && !ready_i) |-> stall_i)
        else $error("stall released while memory held ready low");

endmodule

bind lsu lsu_asserts u_asserts (
    .clk           (clk),
    .rst           (rst),
    .addr_valid_i  (mem_addr_valid_o),
    .write_valid_i (mem_write_valid_o),
    .ready_i       (mem_data_ready_i),
    .done_i        (amo_done_o),
    .stall_i       (stall_o)
);

// File: tb_lsu.sv
`include "lsu_defs.svh"

module tb_lsu;

    localparam logic [31:0] CLINT_PATTERN = 32'hc1a5_7e3d;
    localparam int MAX_ROWS = 64;

    logic        clk;
    logic        rst;
    logic [3:0]  mem_op;
    logic [3:0]  amo_op;
    logic        amo_valid;
    logic [31:0] alu_data;
    logic [31:0] rs2_data;
    logic [31:0] mem_addr;
    logic        mem_addr_valid;
    logic        mem_write_valid;
    logic [3:0]  mem_mask;
    logic [3:0]  mem_size;
    logic [31:0] mem_wdata;
    logic        mem_data_ready;
    logic [31:0] mem_rdata;
    logic [31:0] clint_addr;
    logic        clint_valid;
    logic        clint_write_valid;
    logic [31:0] clint_wdata;
    logic [31:0] clint_rdata;
    logic [31:0] mem_data;
    logic [31:0] amo_result;
    logic        amo_done;
    logic        stall;
    logic        amo_misalign;

    // data memory model storage, word indexed
    logic [31:0] mem [64];

    // stimulus table columns
    logic [3:0]  t_op   [MAX_ROWS];
    logic [3:0]  t_amo  [MAX_ROWS];
    logic [31:0] t_addr [MAX_ROWS];
    logic [31:0] t_rs2  [MAX_ROWS];
    logic [31:0] t_pre  [MAX_ROWS];
    logic        t_load [MAX_ROWS];
    logic [31:0] t_exp  [MAX_ROWS];
    logic [31:0] t_mem  [MAX_ROWS];

    int     num_rows = 0;
    int     checks = 0;
    int     errors = 0;
    int     cycles = 0;
    integer seed = 32'h7a18_20c5;

    lsu UUT (
        .clk                 (clk),
        .rst                 (rst),
        .mem_op_i            (mem_op),
        .amo_op_i            (amo_op),
        .amo_valid_i         (amo_valid),
        .alu_data_i          (alu_data),
        .rs2_data_i          (rs2_data),
        .mem_addr_o          (mem_addr),
        .mem_addr_valid_o    (mem_addr_valid),
        .mem_write_valid_o   (mem_write_valid),
        .mem_mask_o          (mem_mask),
        .mem_size_o          (mem_size),
        .mem_wdata_o         (mem_wdata),
        .mem_data_ready_i    (mem_data_ready),
        .mem_rdata_i         (mem_rdata),
        .clint_addr_o        (clint_addr),
        .clint_valid_o       (clint_valid),
        .clint_write_valid_o (clint_write_valid),
        .clint_wdata_o       (clint_wdata),
        .clint_rdata_i       (clint_rdata),
        .mem_data_o          (mem_data),
        .amo_result_o        (amo_result),
        .amo_done_o          (amo_done),
        .stall_o             (stall),
        .amo_misalign_o      (amo_misalign)
    );

    // clint always reads back one fixed word
    assign clint_rdata = CLINT_PATTERN;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // memory model, ready after 0 to 2 idle cycles
    initial begin
        int          idle;
        logic        pending;
        logic        go;
        logic        w_write;
        logic [3:0]  w_mask;
        logic [5:0]  w_idx;
        logic [31:0] w_data;
        idle = 0;
        pending = 1'b0;
        mem_data_ready = 1'b0;
        mem_rdata = '0;
        for (int i = 0; i < 64; i++) begin
            mem[i] = 32'h9e37_79b9 * (i + 1);
        end
        forever begin
            @(negedge clk);
            go = 1'b0;
            if (!rst && mem_addr_valid && !mem_data_ready) begin
                if (!pending) begin
                    // new request, draw its delay
                    pending = 1'b1;
                    idle = $unsigned($random(seed)) % 3;
                end
                if (idle == 0) begin
                    go = 1'b1;
                    pending = 1'b0;
                    // request drops with ready, so capture it now
                    w_write = mem_write_valid;
                    w_mask = mem_mask;
                    w_idx = mem_addr[7:2];
                    w_data = mem_wdata;
                end else begin
                    idle = idle - 1;
                end
            end
            @(posedge clk);
            #10;
            if (go) begin
                if (w_write) begin
                    for (int b = 0; b < 4; b++) begin
                        if (w_mask[b]) begin
                            mem[w_idx][b*8 +: 8] = w_data[b*8 +: 8];
                        end
                    end
                end
                mem_rdata = mem[w_idx];
                mem_data_ready = 1'b1;
            end else begin
                mem_data_ready = 1'b0;
            end
        end
    end

    // hang guard sized from the table
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > num_rows * 20) begin
            $display("timeout, the DUT did not finish after %0d cycles, %0d errors",
                     cycles, errors);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error: %s is %h, expected %h", name, actual, expected);
        end
    endtask

    // one-hot access width, atomics are word wide
    function automatic logic [3:0] expected_size(input logic [3:0] op);
        case (op)
            `MEMOP_LB, `MEMOP_LBU, `MEMOP_SB: return 4'b0001;
            `MEMOP_LH, `MEMOP_LHU, `MEMOP_SH: return 4'b0010;
            default: return 4'b0100;
        endcase
    endfunction

    task automatic add_row(input logic [3:0] op, input logic [3:0] amo,
                           input logic [31:0] addr, input logic [31:0] rs2,
                           input logic [31:0] pre, input logic load,
                           input logic [31:0] exp_data, input logic [31:0] exp_mem);
        t_op[num_rows] = op;
        t_amo[num_rows] = amo;
        t_addr[num_rows] = addr;
        t_rs2[num_rows] = rs2;
        t_pre[num_rows] = pre;
        t_load[num_rows] = load;
        t_exp[num_rows] = exp_data;
        t_mem[num_rows] = exp_mem;
        num_rows++;
    endtask

    task automatic build_table();
        // op, amo op, address, rs2, preload, preload on, expected data, word after
        add_row(`MEMOP_LB,  4'd0, 'h10, 'h0, 'h8f7e3c91, 1'b1, 'hffffff91, 'h8f7e3c91);
        add_row(`MEMOP_LB,  4'd0, 'h11, 'h0, 'h8f7e3c91, 1'b1, 'h0000003c, 'h8f7e3c91);
        add_row(`MEMOP_LB,  4'd0, 'h12, 'h0, 'h8f7e3c91, 1'b1, 'h0000007e, 'h8f7e3c91);
        add_row(`MEMOP_LB,  4'd0, 'h13, 'h0, 'h8f7e3c91, 1'b1, 'hffffff8f, 'h8f7e3c91);
        add_row(`MEMOP_LBU, 4'd0, 'h10, 'h0, 'h8f7e3c91, 1'b1, 'h00000091, 'h8f7e3c91);
        add_row(`MEMOP_LBU, 4'd0, 'h13, 'h0, 'h8f7e3c91, 1'b1, 'h0000008f, 'h8f7e3c91);
        add_row(`MEMOP_LH,  4'd0, 'h10, 'h0, 'h8f7e3c91, 1'b1, 'h00003c91, 'h8f7e3c91);
        add_row(`MEMOP_LH,  4'd0, 'h12, 'h0, 'h8f7e3c91, 1'b1, 'hffff8f7e, 'h8f7e3c91);
        add_row(`MEMOP_LHU, 4'd0, 'h10, 'h0, 'h8f7e3c91, 1'b1, 'h00003c91, 'h8f7e3c91);
        add_row(`MEMOP_LHU, 4'd0, 'h12, 'h0, 'h8f7e3c91, 1'b1, 'h00008f7e, 'h8f7e3c91);
        add_row(`MEMOP_LW,  4'd0, 'h10, 'h0, 'h8f7e3c91, 1'b1, 'h8f7e3c91, 'h8f7e3c91);
        // stores return the alu value on mem_data_o
        add_row(`MEMOP_SB, 4'd0, 'h20, 'hdeadbea5, 'h11223344, 1'b1, 'h20, 'h112233a5);
        add_row(`MEMOP_SB, 4'd0, 'h21, 'hdeadbea5, 'h11223344, 1'b1, 'h21, 'h1122a544);
        add_row(`MEMOP_SB, 4'd0, 'h22, 'hdeadbea5, 'h11223344, 1'b1, 'h22, 'h11a53344);
        add_row(`MEMOP_SB, 4'd0, 'h23, 'hdeadbea5, 'h11223344, 1'b1, 'h23, 'ha5223344);
        add_row(`MEMOP_LW, 4'd0, 'h20, 'h0, 'h0, 1'b0, 'ha5223344, 'ha5223344);
        add_row(`MEMOP_SH, 4'd0, 'h20, 'hdeadc3b7, 'h11223344, 1'b1, 'h20, 'h1122c3b7);
        add_row(`MEMOP_SH, 4'd0, 'h22, 'hdeadc3b7, 'h11223344, 1'b1, 'h22, 'hc3b73344);
        add_row(`MEMOP_SW, 4'd0, 'h20, 'hcafef00d, 'h11223344, 1'b1, 'h20, 'hcafef00d);
        add_row(`MEMOP_LW, 4'd0, 'h20, 'h0, 'h0, 1'b0, 'hcafef00d, 'hcafef00d);
        // clint rows, store expects rs2 on clint_wdata_o
        add_row(`MEMOP_LW, 4'd0, `MTIME_ADDR_LOW, 'h0, 'h0, 1'b0, CLINT_PATTERN, 'h0);
        add_row(`MEMOP_LH, 4'd0, `MTIME_ADDR_HIGH, 'h0, 'h0, 1'b0, 'h00007e3d, 'h0);
        add_row(`MEMOP_SW, 4'd0, `MTIMECMP_ADDR_LOW, 'h1234, 'h0, 1'b0, 'h1234, 'h0);
        // amo rows, result is always the old word
        add_row(`MEMOP_AMO, `AMOOP_SWAP, 'h30, 'h135, 'h80000010, 1'b1, 'h80000010, 'h135);
        add_row(`MEMOP_AMO, `AMOOP_ADD,  'h30, 'h135, 'h80000010, 1'b1, 'h80000010, 'h80000145);
        add_row(`MEMOP_AMO, `AMOOP_XOR,  'h30, 'h135, 'h80000010, 1'b1, 'h80000010, 'h80000125);
        add_row(`MEMOP_AMO, `AMOOP_AND,  'h30, 'h135, 'h80000010, 1'b1, 'h80000010, 'h10);
        add_row(`MEMOP_AMO, `AMOOP_OR,   'h30, 'h135, 'h80000010, 1'b1, 'h80000010, 'h80000135);
        add_row(`MEMOP_AMO, `AMOOP_MIN,  'h30, 'h135, 'h80000010, 1'b1, 'h80000010, 'h80000010);
        add_row(`MEMOP_AMO, `AMOOP_MAX,  'h30, 'h135, 'h80000010, 1'b1, 'h80000010, 'h135);
        add_row(`MEMOP_AMO, `AMOOP_MINU, 'h30, 'h135, 'h80000010, 1'b1, 'h80000010, 'h135);
        add_row(`MEMOP_AMO, `AMOOP_MAXU, 'h30, 'h135, 'h80000010, 1'b1, 'h80000010, 'h80000010);
        // both negative
        add_row(`MEMOP_AMO, `AMOOP_MIN, 'h34, 'hfffffff5, 'hfffffff0, 1'b1, 'hfffffff0, 'hfffffff0);
        add_row(`MEMOP_AMO, `AMOOP_MAX, 'h34, 'hfffffff5, 'hfffffff0, 1'b1, 'hfffffff0, 'hfffffff5);
        // lr/sc pairs and reservation loss
        add_row(`MEMOP_LR_W, 4'd0, 'h40, 'h0, 'h0badf00d, 1'b1, 'h0badf00d, 'h0badf00d);
        add_row(`MEMOP_SC_W, 4'd0, 'h40, 'h600dc0de, 'h0, 1'b0, 'h0, 'h600dc0de);
        add_row(`MEMOP_SC_W, 4'd0, 'h40, 'h12345678, 'h0, 1'b0, 'h1, 'h600dc0de);
        add_row(`MEMOP_LR_W, 4'd0, 'h40, 'h0, 'h0, 1'b0, 'h600dc0de, 'h600dc0de);
        add_row(`MEMOP_SW,   4'd0, 'h44, 'haaaa5555, 'h0, 1'b1, 'h44, 'haaaa5555);
        add_row(`MEMOP_SC_W, 4'd0, 'h40, 'h11111111, 'h0, 1'b0, 'h1, 'h600dc0de);
        add_row(`MEMOP_LR_W, 4'd0, 'h48, 'h0, 'h00c0ffee, 1'b1, 'h00c0ffee, 'h00c0ffee);
        add_row(`MEMOP_SC_W, 4'd0, 'h4c, 'h55, 'h01020304, 1'b1, 'h1, 'h01020304);
    endtask

    task automatic run_row(input int r);
        logic [5:0] idx;
        logic       is_atom;
        logic       is_store;
        logic       is_clint;
        logic       exp_mis;
        idx = t_addr[r][7:2];
        is_atom = (t_op[r] == `MEMOP_LR_W) || (t_op[r] == `MEMOP_SC_W) ||
                  (t_op[r] == `MEMOP_AMO);
        is_store = (t_op[r] == `MEMOP_SB) || (t_op[r] == `MEMOP_SH) ||
                   (t_op[r] == `MEMOP_SW);
        is_clint = (t_addr[r] == `MTIME_ADDR_LOW) || (t_addr[r] == `MTIME_ADDR_HIGH) ||
                   (t_addr[r] == `MTIMECMP_ADDR_LOW) || (t_addr[r] == `MTIMECMP_ADDR_HIGH);
        exp_mis = is_atom && (t_addr[r][1:0] != 2'b00);
        @(posedge clk);
        #10;
        if (t_load[r]) begin
            mem[idx] = t_pre[r];
        end
        mem_op = t_op[r];
        amo_op = t_amo[r];
        alu_data = t_addr[r];
        rs2_data = t_rs2[r];
        amo_valid = is_atom;
        @(negedge clk);
        check_value("amo_misalign_o", 32'(amo_misalign), 32'(exp_mis));
        check_value("mem_size_o", 32'(mem_size), 32'(expected_size(t_op[r])));
        if (is_clint) begin
            // answered in the same cycle, memory stays quiet
            check_value("mem_addr_valid_o", 32'(mem_addr_valid), 32'd0);
            check_value("stall_o", 32'(stall), 32'd0);
            check_value("clint_valid_o", 32'(clint_valid), 32'd1);
            check_value("clint_addr_o", clint_addr, t_addr[r]);
            if (is_store) begin
                check_value("clint_write_valid_o", 32'(clint_write_valid), 32'd1);
                check_value("clint_wdata_o", clint_wdata, t_exp[r]);
            end else begin
                check_value("mem_data_o", mem_data, t_exp[r]);
            end
        end else begin
            if (is_atom) begin
                while (!amo_done) @(negedge clk);
                check_value("amo_result_o", amo_result, t_exp[r]);
                // pipeline released together with done
                check_value("stall_o", 32'(stall), 32'd0);
            end else begin
                // request is up and unanswered
                check_value("stall_o", 32'(stall), 32'd1);
                // load data is valid only in the ready cycle
                while (!mem_data_ready) @(negedge clk);
                check_value("mem_data_o", mem_data, t_exp[r]);
            end
            check_value($sformatf("mem[%0d]", idx), mem[idx], t_mem[r]);
        end
        // one idle cycle so the next atomic sees a fresh edge
        @(posedge clk);
        #10;
        mem_op = `MEMOP_NONE;
        amo_valid = 1'b0;
    endtask

    // atomic ops off a word boundary, no start edge given
    task automatic check_misalign();
        logic [3:0] ops [3];
        ops[0] = `MEMOP_LR_W;
        ops[1] = `MEMOP_SC_W;
        ops[2] = `MEMOP_AMO;
        for (int k = 0; k < 3; k++) begin
            for (int off = 1; off < 4; off++) begin
                @(posedge clk);
                #10;
                mem_op = ops[k];
                alu_data = 32'h50 + off;
                @(negedge clk);
                check_value("amo_misalign_o", 32'(amo_misalign), 32'd1);
            end
        end
        @(posedge clk);
        #10;
        mem_op = `MEMOP_NONE;
    endtask

    initial begin
        rst = 1'b1;
        mem_op = `MEMOP_NONE;
        amo_op = `AMOOP_SWAP;
        amo_valid = 1'b0;
        alu_data = '0;
        rs2_data = '0;
        build_table();
        repeat (8) @(posedge clk);
        #10;
        rst = 1'b0;
        for (int r = 0; r < num_rows; r++) begin
            run_row(r);
        end
        check_misalign();
        $display("%0d rows, %0d checks, %0d errors", num_rows, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+.
lsu_pkg.sv
lsu_access_decode.sv
lsu_store_align.sv
lsu_load_extend.sv
lsu_amo_unit.sv
lsu.sv
lsu_asserts.sv
tb_lsu.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_lsu
FILELIST   := tb.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0 --Mdir $(OBJ_DIR)
PASS_MSG   := ALL CHECKS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
